//--- include/eth_tx_consts.svh
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

////////////////////
// Wire bytes
////////////////////

`define ETH_PREAMBLE_BYTE 8'h55   // Alternating ones and zeros
`define ETH_SFD_BYTE      8'hD5   // Start of frame delimiter
`define ETH_PAD_BYTE      8'h00   // Filler for short bodies

////////////////////
// Frame lengths
////////////////////

`define ETH_PREAMBLE_LEN  7       // Preamble bytes before the SFD
`define ETH_MIN_BODY      60      // Dst, src, length/type and payload, without FCS
`define ETH_FCS_LEN       4       // CRC-32 bytes

// Inter-frame gap in clocks, 96 bit times at a fixed 125 MHz core clock
`define ETH_IFG_1G        11'd12
`define ETH_IFG_100M      11'd120
`define ETH_IFG_10M       11'd1200

`endif

//--- source/eth_tx_pkg.sv
package eth_tx_pkg;

    ////////////////////
    // Frame phase
    ////////////////////

    // One phase per group of wire bytes
    typedef enum logic [2:0] {
        IDLE,       // Waiting for a body on the stream
        PREAMBLE,   // Seven 0x55 bytes
        SFD,        // Delimiter byte
        BODY,       // Bytes taken from the stream
        PAD,        // Zero fill up to the minimum body
        FCS,        // Four CRC bytes, low byte first
        GAP         // Inter-frame gap, tx_dv low
    } tx_phase_t;

    ////////////////////
    // FCS word
    ////////////////////

    // Same 32 bits seen as one word or as four wire bytes
    // bytes[0] is word[7:0] and goes out first
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } fcs_word_u;

endpackage

//--- source/crc32_engine.sv
module crc32_engine (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  clear,     // Frame start, back to all ones
    input  logic                  enable,    // Fold data in on this clock
    input  logic [7:0]            data,
    output eth_tx_pkg::fcs_word_u fcs        // Complemented CRC, ready for the wire
);

    // Reflected form of 0x04C11DB7
    localparam logic [31:0] CRC_POLY_REV = 32'hEDB8_8320;

    logic [31:0] crc_q;      // Running remainder
    logic [31:0] crc_next;

    // One byte, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                             input logic [7:0]  byte_in);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ byte_in[i];               // Feedback bit
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ CRC_POLY_REV;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, data);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            crc_q <= '1;                          // Preset to all ones
        end else if (clear) begin
            crc_q <= '1;
        end else if (enable) begin
            crc_q <= crc_next;
        end
    end

    // Final XOR; byte 0 of the union is the first FCS byte sent
    assign fcs.word = ~crc_q;

endmodule

//--- source/tx_frame_ctrl.sv
`include "eth_tx_consts.svh"

module tx_frame_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  tvalid,
    input  logic                  tlast,
    input  logic                  tx_rdy,        // PHY ready, stalls everything when low
    input  logic                  rx_pause,      // Hold off the next frame
    input  logic                  nibble_busy,   // Mux still owes the high nibble
    input  logic                  gap_done,
    output eth_tx_pkg::tx_phase_t phase,
    output logic                  advance,       // One output byte slot this clock
    output logic                  body_ok,       // Body byte accepted
    output logic                  tready,
    output logic                  crc_clear,
    output logic [1:0]            byte_index,    // FCS byte number
    output logic                  gap_start
);

    localparam logic [2:0] PRE_LAST  = 3'(`ETH_PREAMBLE_LEN - 1);
    localparam logic [5:0] BODY_LAST = 6'(`ETH_MIN_BODY - 1);
    localparam logic [5:0] BODY_MIN  = 6'(`ETH_MIN_BODY);
    localparam logic [1:0] FCS_LAST  = 2'(`ETH_FCS_LEN - 1);

    logic [2:0] pre_cnt;     // Preamble bytes sent so far
    logic [5:0] body_cnt;    // Body plus pad bytes, saturates at the minimum
    logic       frame_go;    // Start of a new frame

    ////////////////////
    // Handshake
    ////////////////////

    // A byte slot exists only when the PHY takes data and no nibble is pending
    assign advance = tx_rdy && !nibble_busy;

    assign tready  = (phase == eth_tx_pkg::BODY) && advance;
    assign body_ok = tready && tvalid;

    // New frame only from IDLE, with data waiting and no pause
    assign frame_go  = (phase == eth_tx_pkg::IDLE) && tvalid && !rx_pause && advance;
    assign crc_clear = frame_go;

    // Gap timer starts together with the last FCS byte
    assign gap_start = (phase == eth_tx_pkg::FCS) && advance && (byte_index == FCS_LAST);

    ////////////////////
    // Phase sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            phase      <= eth_tx_pkg::IDLE;
            pre_cnt    <= '0;
            body_cnt   <= '0;
            byte_index <= '0;
        end else if (advance) begin
            case (phase)
                eth_tx_pkg::IDLE: begin
                    if (frame_go) begin
                        phase      <= eth_tx_pkg::PREAMBLE;
                        pre_cnt    <= '0;
                        body_cnt   <= '0;
                        byte_index <= '0;
                    end
                end

                eth_tx_pkg::PREAMBLE: begin
                    if (pre_cnt == PRE_LAST) begin
                        phase <= eth_tx_pkg::SFD;    // Seventh 0x55 goes out now
                    end else begin
                        pre_cnt <= pre_cnt + 3'd1;
                    end
                end

                eth_tx_pkg::SFD: begin
                    phase <= eth_tx_pkg::BODY;
                end

                eth_tx_pkg::BODY: begin
                    if (body_ok) begin
                        // Only the first 60 bytes matter for padding
                        if (body_cnt != BODY_MIN) begin
                            body_cnt <= body_cnt + 6'd1;
                        end
                        if (tlast) begin
                            // Count before this byte, so 59 means 60 with it
                            if (body_cnt >= BODY_LAST) begin
                                phase <= eth_tx_pkg::FCS;
                            end else begin
                                phase <= eth_tx_pkg::PAD;
                            end
                        end
                    end
                end

                eth_tx_pkg::PAD: begin
                    body_cnt <= body_cnt + 6'd1;
                    if (body_cnt == BODY_LAST) begin
                        phase <= eth_tx_pkg::FCS;    // 60th byte is this pad byte
                    end
                end

                eth_tx_pkg::FCS: begin
                    byte_index <= byte_index + 2'd1; // Wraps to 0 after the fourth byte
                    if (byte_index == FCS_LAST) begin
                        phase <= eth_tx_pkg::GAP;
                    end
                end

                eth_tx_pkg::GAP: begin
                    if (gap_done) begin
                        phase <= eth_tx_pkg::IDLE;
                    end
                end

                default: begin
                    phase <= eth_tx_pkg::IDLE;       // Unused encoding
                end
            endcase
        end
    end

endmodule

//--- source/tx_octet_mux.sv
`include "eth_tx_consts.svh"

module tx_octet_mux (
    input  logic                  clk,
    input  logic                  reset_n,
    input  eth_tx_pkg::tx_phase_t phase,
    input  logic                  advance,
    input  logic                  tx_rdy,
    input  logic                  mii_select,    // Nibble mode, low nibble first
    input  logic [7:0]            tdata,
    input  eth_tx_pkg::fcs_word_u fcs,
    input  logic [1:0]            byte_index,
    output logic [7:0]            tx_data,
    output logic                  tx_dv,
    output logic                  nibble_busy    // High nibble goes out next
);

    logic [7:0] sel_byte;    // Byte for the current phase
    logic       sel_dv;      // Phase puts a byte on the wire
    logic [3:0] hi_nibble;   // Saved upper half in nibble mode

    // Byte source by phase
    always_comb begin
        sel_byte = `ETH_PAD_BYTE;
        sel_dv   = 1'b1;
        case (phase)
            eth_tx_pkg::PREAMBLE: sel_byte = `ETH_PREAMBLE_BYTE;
            eth_tx_pkg::SFD:      sel_byte = `ETH_SFD_BYTE;
            eth_tx_pkg::BODY:     sel_byte = tdata;
            eth_tx_pkg::PAD:      sel_byte = `ETH_PAD_BYTE;
            eth_tx_pkg::FCS:      sel_byte = fcs.bytes[byte_index];   // Union viewed as bytes
            default:              sel_dv   = 1'b0;                    // IDLE and GAP
        endcase
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            tx_data     <= '0;
            tx_dv       <= 1'b0;
            nibble_busy <= 1'b0;
        end else if (tx_rdy) begin               // Everything holds on a PHY stall
            if (nibble_busy) begin
                tx_data     <= {4'h0, hi_nibble};  // Second half, tx_dv unchanged
                nibble_busy <= 1'b0;
            end else if (advance) begin
                tx_dv <= sel_dv;
                if (mii_select) begin
                    tx_data     <= {4'h0, sel_byte[3:0]};
                    nibble_busy <= sel_dv;         // No second half for idle slots
                end else begin
                    tx_data <= sel_byte;
                end
            end
        end
    end

    // Upper half captured with the low one
    always_ff @(posedge clk) begin
        if (advance && mii_select) begin
            hi_nibble <= sel_byte[7:4];
        end
    end

endmodule

//--- source/ifg_timer.sv
`include "eth_tx_consts.svh"

module ifg_timer (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start,        // Last FCS byte is leaving
    input  logic [1:0] link_speed,   // 00 10M, 01 100M, others 1G
    output logic       gap_done
);

    logic [10:0] gap_cnt;    // Clocks left in the gap
    logic [10:0] gap_len;

    // Gap length by link speed
    always_comb begin
        case (link_speed)
            2'b00:   gap_len = `ETH_IFG_10M;
            2'b01:   gap_len = `ETH_IFG_100M;
            default: gap_len = `ETH_IFG_1G;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            gap_cnt <= '0;                   // Idle timer reads as done
        end else if (start) begin
            gap_cnt <= gap_len;
        end else if (gap_cnt != 11'd0) begin
            gap_cnt <= gap_cnt - 11'd1;
        end
    end

    // Stays high until the next start
    assign gap_done = (gap_cnt == 11'd0);

endmodule

//--- source/eth_tx_top.sv
`include "eth_tx_consts.svh"

module eth_tx_top (
    input  logic       clk,
    input  logic       reset_n,
    // Frame body stream
    input  logic [7:0] tdata,
    input  logic       tvalid,
    input  logic       tlast,
    output logic       tready,
    // PHY side
    input  logic       tx_rdy,
    output logic [7:0] tx_data,
    output logic       tx_dv,
    // Control
    input  logic       rx_pause,
    input  logic       mii_select,
    input  logic [1:0] link_speed
);

    eth_tx_pkg::tx_phase_t phase;
    eth_tx_pkg::fcs_word_u fcs;
    logic       advance;
    logic       body_ok;
    logic       crc_clear;
    logic [1:0] byte_index;
    logic       gap_start;
    logic       gap_done;
    logic       nibble_busy;
    logic       crc_en;      // Body or pad byte enters the CRC
    logic [7:0] crc_data;

    ////////////////////
    // CRC input select
    ////////////////////

    assign crc_en   = body_ok || ((phase == eth_tx_pkg::PAD) && advance);
    assign crc_data = (phase == eth_tx_pkg::PAD) ? `ETH_PAD_BYTE : tdata;

    // Frame controller
    tx_frame_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .tvalid      (tvalid),
        .tlast       (tlast),
        .tx_rdy      (tx_rdy),
        .rx_pause    (rx_pause),
        .nibble_busy (nibble_busy),
        .gap_done    (gap_done),
        .phase       (phase),
        .advance     (advance),
        .body_ok     (body_ok),
        .tready      (tready),
        .crc_clear   (crc_clear),
        .byte_index  (byte_index),
        .gap_start   (gap_start)
    );

    crc32_engine u_crc (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (crc_clear),
        .enable  (crc_en),
        .data    (crc_data),
        .fcs     (fcs)
    );

    // Byte and nibble output stage
    tx_octet_mux u_mux (
        .clk         (clk),
        .reset_n     (reset_n),
        .phase       (phase),
        .advance     (advance),
        .tx_rdy      (tx_rdy),
        .mii_select  (mii_select),
        .tdata       (tdata),
        .fcs         (fcs),
        .byte_index  (byte_index),
        .tx_data     (tx_data),
        .tx_dv       (tx_dv),
        .nibble_busy (nibble_busy)
    );

    ifg_timer u_ifg (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (gap_start),
        .link_speed (link_speed),
        .gap_done   (gap_done)
    );

endmodule

//--- dv/eth_tx_chk.sv
module eth_tx_chk (
    input logic                  clk,
    input logic                  reset_n,
    input eth_tx_pkg::tx_phase_t phase,
    input logic                  advance,    // Output byte slot in the controller
    input logic                  tvalid,
    input logic                  tlast,
    input logic                  tready,
    input logic                  tx_rdy,
    input logic [7:0]            tx_data,
    input logic                  tx_dv
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // Stream side
    ////////////////////

    // Stream read only while a frame is on the wire and never past its tlast beat
    a_tready_body: assert property (@(posedge clk) disable iff (reset_n)
        tready |-> (tx_dv && !$past(tvalid && tready && tlast)))
        else $error("tready high outside the body of a frame");

    ////////////////////
    // PHY side
    ////////////////////

    // A stalled PHY keeps seeing the same transfer
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_n)
        !tx_rdy |=> ($stable(tx_data) && $stable(tx_dv)))
        else $error("tx_data or tx_dv changed while tx_rdy was low");

    // Gap slots clear tx_dv on the next clock
    a_gap_quiet: assert property (@(posedge clk) disable iff (reset_n)
        ((phase == eth_tx_pkg::GAP) && advance) |=> !tx_dv)
        else $error("tx_dv high during the inter-frame gap");

endmodule

//--- dv/eth_tx_tb.sv
`include "eth_tx_consts.svh"

module eth_tx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FRAMES = 12;

    // Per frame: short body, nibble mode, PHY stalls, link speed, pause clocks
    localparam bit         SHORT [NUM_FRAMES] = '{0, 1, 0, 1, 0, 1, 0, 0, 1, 0, 1, 1};
    localparam bit         MII   [NUM_FRAMES] = '{0, 0, 0, 0, 0, 1, 1, 0, 0, 1, 1, 0};
    localparam bit         STALL [NUM_FRAMES] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 0};
    localparam logic [1:0] SPEED [NUM_FRAMES] = '{2'b10, 2'b01, 2'b00, 2'b11, 2'b10, 2'b10,
                                                  2'b10, 2'b10, 2'b11, 2'b10, 2'b10, 2'b10};
    localparam int         PAUSE [NUM_FRAMES] = '{0, 0, 0, 0, 60, 0, 0, 0, 0, 0, 50, 0};

    logic       clk;
    logic       reset_n;
    logic [7:0] tdata;
    logic       tvalid;
    logic       tlast;
    logic       tready;
    logic       tx_rdy;
    logic [7:0] tx_data;
    logic       tx_dv;
    logic       rx_pause;
    logic       mii_select;
    logic [1:0] link_speed;

    logic       stall_en;               // Random tx_rdy drops
    logic [7:0] exp_q[$];               // Wire bytes still owed by the DUT
    int         frame_len[NUM_FRAMES];
    int         errors;
    int         beats;                  // Body bytes taken in this frame
    int         low_cnt;                // Clocks with tx_dv low since the last frame
    int         gap_need;               // Shortest legal gap, 0 when not timed
    int         budget;                 // Watchdog limit in clocks
    logic       nib_half;               // Low nibble already collected
    logic [3:0] nib_lo;

    eth_tx_top uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .tdata      (tdata),
        .tvalid     (tvalid),
        .tlast      (tlast),
        .tready     (tready),
        .tx_rdy     (tx_rdy),
        .tx_data    (tx_data),
        .tx_dv      (tx_dv),
        .rx_pause   (rx_pause),
        .mii_select (mii_select),
        .link_speed (link_speed)
    );

    bind eth_tx_top eth_tx_chk u_chk (
        .clk     (clk),
        .reset_n (reset_n),
        .phase   (phase),
        .advance (advance),
        .tvalid  (tvalid),
        .tlast   (tlast),
        .tready  (tready),
        .tx_rdy  (tx_rdy),
        .tx_data (tx_data),
        .tx_dv   (tx_dv)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    ////////////////////
    // Checking
    ////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    // Preamble, SFD, body padded to the minimum, then FCS low byte first
    function automatic void build_expected(input logic [7:0] body[$]);
        eth_tx_pkg::fcs_word_u fcs;
        logic [31:0]           crc;
        logic [7:0]            b;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
            exp_q.push_back(`ETH_PREAMBLE_BYTE);
        end
        exp_q.push_back(`ETH_SFD_BYTE);
        for (int i = 0; i < body.size() || i < `ETH_MIN_BODY; i++) begin
            b = (i < body.size()) ? body[i] : `ETH_PAD_BYTE;
            exp_q.push_back(b);
            for (int k = 0; k < 8; k++) begin
                crc = (crc[0] ^ b[k]) ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
            end
        end
        fcs.word = ~crc;
        for (int i = 0; i < `ETH_FCS_LEN; i++) begin
            exp_q.push_back(fcs.bytes[i]);
        end
    endfunction

    task automatic take_byte(input logic [7:0] b);
        if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: byte %0h sent while no frame was pending", $time, b);
        end else begin
            compare_value("tx_data", 32'(b), 32'(exp_q.pop_front()));
        end
    endtask

    // Wire monitor, a byte counts when the PHY is ready for it
    always @(posedge clk) begin
        if (!reset_n) begin
            if (tvalid && tready) begin
                beats++;
            end
            if (tx_dv && tx_rdy) begin
                if (mii_select) begin
                    compare_value("tx_data[7:4]", 32'(tx_data[7:4]), 32'd0);
                    if (nib_half) begin
                        take_byte({tx_data[3:0], nib_lo});   // High half completes it
                    end else begin
                        nib_lo = tx_data[3:0];
                    end
                    nib_half = !nib_half;
                end else begin
                    take_byte(tx_data);
                end
            end
            if (!tx_dv) begin
                low_cnt++;
            end else if (low_cnt != 0) begin
                if (low_cnt < gap_need) begin
                    errors++;
                    $display("ERROR at %0t: tx_dv gap is %0d clocks, expected at least %0d",
                             $time, low_cnt, gap_need);
                end
                low_cnt = 0;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // PHY back-pressure, about one clock in four
    always @(negedge clk) begin
        tx_rdy = stall_en ? ($urandom_range(3) != 0) : 1'b1;
    end

    task automatic run_frame(input int idx);
        logic [7:0] body[$];
        int         n;
        n = frame_len[idx];
        for (int i = 0; i < n; i++) begin
            body.push_back(8'($urandom_range(255)));
        end
        build_expected(body);
        @(negedge clk);
        mii_select = MII[idx];
        link_speed = SPEED[idx];
        rx_pause   = (PAUSE[idx] != 0);
        stall_en  <= STALL[idx];
        beats      = 0;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    tvalid = 1'b1;
                    tdata  = body[i];
                    tlast  = (i == n - 1);
                    do begin
                        @(posedge clk);
                    end while (!tready);
                    @(negedge clk);
                end
                tlast  = 1'b0;          // Left valid so an extra beat shows in the count
            end
            begin
                repeat (PAUSE[idx]) begin
                    @(posedge clk);
                    compare_value("tx_dv", 32'(tx_dv), 32'd0);   // Held off by rx_pause
                end
                @(negedge clk);
                rx_pause = 1'b0;
            end
        join
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        tvalid = 1'b0;                  // Whole frame is out and the DUT is in its gap
        compare_value("tvalid&tready beats", 32'(beats), 32'(n));
        // Gap timed only after an unstalled byte-mode frame
        if (MII[idx] || STALL[idx]) begin
            gap_need = 0;
        end else begin
            case (SPEED[idx])
                2'b00:   gap_need = 32'(`ETH_IFG_10M);
                2'b01:   gap_need = 32'(`ETH_IFG_100M);
                default: gap_need = 32'(`ETH_IFG_1G);
            endcase
        end
    endtask

    initial begin
        reset_n    = 1'b1;
        tdata      = 8'h00;
        tvalid     = 1'b0;
        tlast      = 1'b0;
        tx_rdy     = 1'b1;
        rx_pause   = 1'b0;
        mii_select = 1'b0;
        link_speed = 2'b10;
        stall_en  <= 1'b0;
        errors     = 0;
        beats      = 0;
        low_cnt    = 0;
        gap_need   = 0;
        nib_half   = 1'b0;
        nib_lo     = 4'h0;
        void'($urandom(32'hefa9_75e4));
        budget = 64;                    // Reset and final drain
        for (int i = 0; i < NUM_FRAMES; i++) begin
            frame_len[i] = SHORT[i] ? $urandom_range(59, 14) : $urandom_range(200, 64);
            budget += 2 * (`ETH_PREAMBLE_LEN + 1 + `ETH_FCS_LEN
                           + ((frame_len[i] > `ETH_MIN_BODY) ? frame_len[i] : `ETH_MIN_BODY))
                      + 1300 + PAUSE[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(i);
        end
        repeat (20) @(posedge clk);
        $display("Run finished: %0d frames, %0d errors", NUM_FRAMES, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #1;
        repeat (budget) @(posedge clk);
        $display("Timeout: frames still pending after %0d clocks", budget);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
source/eth_tx_pkg.sv
source/crc32_engine.sv
source/tx_frame_ctrl.sv
source/tx_octet_mux.sv
source/ifg_timer.sv
source/eth_tx_top.sv
dv/eth_tx_chk.sv
dv/eth_tx_tb.sv

//--- Makefile
# Verilator flow for the Ethernet transmit MAC testbench
# Any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= eth_tx_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides, so a run stopped by an assertion also fails
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
